// File: mips_isa_pkg.sv
package mips_isa_pkg;

    ////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////

    // data word and address width
    localparam int WORD_W = 32;
    // register file index width
    localparam int REG_ADDR_W = 5;
    // delay slot sits one instruction after its branch
    localparam int PC_STEP = 4;
    localparam int EXC_CODE_WIDTH = 5;

    ////////////////////////////////////////////////////////////
    // opcodes as encoded by execute
    ////////////////////////////////////////////////////////////

    // anything not listed is treated as non-memory
    typedef enum logic [7:0] {
        OP_NOP = 8'h00,
        OP_LB  = 8'h20,
        OP_LH  = 8'h21,
        OP_LW  = 8'h23,
        OP_LBU = 8'h24,
        OP_LHU = 8'h25,
        OP_SB  = 8'h28,
        OP_SH  = 8'h29,
        OP_SW  = 8'h2B
    } aluop_e;

    // exception codes seen in this stage
    // all ones means no exception pending
    typedef enum logic [EXC_CODE_WIDTH-1:0] {
        EC_NONE = 5'h1F,
        EC_ADEL = 5'h04,
        EC_ADES = 5'h05
    } exc_code_e;

endpackage

// File: mem_bus_pkg.sv
package mem_bus_pkg;

    // byte lanes on the data ram port
    localparam int LANES = 4;
    // bits needed to index one lane
    localparam int LANE_IDX_W = $clog2(LANES);
    // kseg style mapping, top address bits dropped
    localparam int PHYS_MASK_BITS = 3;

    // one bit per byte lane, bit 0 is the lowest address
    typedef logic [LANES-1:0] lane_sel_t;

    localparam lane_sel_t SEL_NONE = '0;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } access_size_e;

    // lane pattern of an access sitting at lane 0
    function automatic lane_sel_t size_pattern(access_size_e sz);
        case (sz)
            SZ_BYTE: return lane_sel_t'(1);
            SZ_HALF: return lane_sel_t'(3);
            SZ_WORD: return '1;
            default: return SEL_NONE;
        endcase
    endfunction

endpackage

// File: mem_access_ctrl.sv
`timescale 1ns/10ps

module mem_access_ctrl #(
    parameter int DATA_W = 32
) (
    input  logic                                     arst_n_i,
    input  mips_isa_pkg::aluop_e                     aluop_i,
    input  logic [DATA_W-1:0]                        addr_i,
    output logic                                     ram_ce_o,
    output logic                                     ram_we_o,
    output mem_bus_pkg::lane_sel_t                   ram_sel_o,
    output logic [DATA_W-1:0]                        ram_addr_o,
    output mem_bus_pkg::access_size_e                size_o,
    output logic                                     sign_ext_o,
    output logic                                     is_load_o,
    output logic [mem_bus_pkg::LANE_IDX_W-1:0]       lane_o,
    output logic                                     fault_o,
    output mips_isa_pkg::exc_code_e                  fault_code_o
);

    logic is_mem;
    logic is_store;
    logic aligned;

    ////////////////////////////////////////////////////////////
    // opcode decode
    ////////////////////////////////////////////////////////////

    // defaults describe a word store
    always_comb begin
        is_mem     = 1'b1;
        is_load_o  = 1'b0;
        size_o     = mem_bus_pkg::SZ_WORD;
        sign_ext_o = 1'b0;
        case (aluop_i)
            mips_isa_pkg::OP_LB: begin
                is_load_o  = 1'b1;
                size_o     = mem_bus_pkg::SZ_BYTE;
                sign_ext_o = 1'b1;
            end
            mips_isa_pkg::OP_LBU: begin
                is_load_o = 1'b1;
                size_o    = mem_bus_pkg::SZ_BYTE;
            end
            mips_isa_pkg::OP_LH: begin
                is_load_o  = 1'b1;
                size_o     = mem_bus_pkg::SZ_HALF;
                sign_ext_o = 1'b1;
            end
            mips_isa_pkg::OP_LHU: begin
                is_load_o = 1'b1;
                size_o    = mem_bus_pkg::SZ_HALF;
            end
            mips_isa_pkg::OP_LW: begin
                is_load_o = 1'b1;
            end
            mips_isa_pkg::OP_SB: begin
                size_o = mem_bus_pkg::SZ_BYTE;
            end
            mips_isa_pkg::OP_SH: begin
                size_o = mem_bus_pkg::SZ_HALF;
            end
            mips_isa_pkg::OP_SW: begin
                size_o = mem_bus_pkg::SZ_WORD;
            end
            // nop and every alu result
            default: is_mem = 1'b0;
        endcase
    end

    assign is_store = is_mem & ~is_load_o;
    assign lane_o   = addr_i[mem_bus_pkg::LANE_IDX_W-1:0];

    ////////////////////////////////////////////////////////////
    // alignment check and lane select
    ////////////////////////////////////////////////////////////

    // halfword needs an even address, word needs lane 0
    always_comb begin
        case (size_o)
            mem_bus_pkg::SZ_BYTE: aligned = 1'b1;
            mem_bus_pkg::SZ_HALF: aligned = ~lane_o[0];
            default:              aligned = (lane_o == '0);
        endcase
    end

    assign fault_o = is_mem & ~aligned;

    // adel for loads, ades for stores
    always_comb begin
        if (!fault_o) begin
            fault_code_o = mips_isa_pkg::EC_NONE;
        end else if (is_load_o) begin
            fault_code_o = mips_isa_pkg::EC_ADEL;
        end else begin
            fault_code_o = mips_isa_pkg::EC_ADES;
        end
    end

    // size pattern moved up to the addressed lane
    assign ram_sel_o = (is_mem && aligned) ?
                       (mem_bus_pkg::size_pattern(size_o) << lane_o) :
                       mem_bus_pkg::SEL_NONE;

    // physical address, top bits cleared
    assign ram_addr_o = is_mem ?
                        {{mem_bus_pkg::PHYS_MASK_BITS{1'b0}},
                         addr_i[DATA_W-mem_bus_pkg::PHYS_MASK_BITS-1:0]} :
                        '0;

    // ram strobes held low while in reset
    assign ram_ce_o = arst_n_i & is_mem;
    assign ram_we_o = arst_n_i & is_store;

endmodule

// File: store_align.sv
`timescale 1ns/10ps

module store_align #(
    parameter int DATA_W = 32
) (
    input  logic [DATA_W-1:0]                  reg2_i,
    input  mem_bus_pkg::access_size_e          size_i,
    input  logic [mem_bus_pkg::LANE_IDX_W-1:0] lane_i,
    input  logic                               is_store_i,
    output logic [DATA_W-1:0]                  ram_wdata_o
);

    // bits per byte lane
    localparam int LANE_W = DATA_W / mem_bus_pkg::LANES;

    logic [DATA_W-1:0] trimmed;

    // keep only the low byte or halfword of the source register
    always_comb begin
        case (size_i)
            mem_bus_pkg::SZ_BYTE: trimmed = {{(DATA_W-LANE_W){1'b0}}, reg2_i[LANE_W-1:0]};
            mem_bus_pkg::SZ_HALF: trimmed = {{(DATA_W-2*LANE_W){1'b0}},
                                             reg2_i[2*LANE_W-1:0]};
            default:              trimmed = reg2_i;
        endcase
    end

    // move into the addressed lanes
    // lanes outside the access stay zero
    assign ram_wdata_o = is_store_i ? (trimmed << (lane_i * LANE_W)) : '0;

endmodule

// File: load_extract.sv
`timescale 1ns/10ps

module load_extract #(
    parameter int DATA_W = 32
) (
    input  logic [DATA_W-1:0]                  ram_rdata_i,
    input  logic [DATA_W-1:0]                  ex_wdata_i,
    input  mem_bus_pkg::access_size_e          size_i,
    input  logic                               sign_ext_i,
    input  logic                               is_load_i,
    input  logic [mem_bus_pkg::LANE_IDX_W-1:0] lane_i,
    input  logic                               fault_i,
    output logic [DATA_W-1:0]                  wdata_o
);

    localparam int LANE_W = DATA_W / mem_bus_pkg::LANES;
    localparam int HALF_W = 2 * LANE_W;

    logic [DATA_W-1:0] shifted;
    logic              byte_msb;
    logic              half_msb;
    logic [DATA_W-1:0] loaded;

    // addressed lane brought down to bit 0
    assign shifted = ram_rdata_i >> (lane_i * LANE_W);

    // fill bit, zero for the unsigned loads
    assign byte_msb = sign_ext_i & shifted[LANE_W-1];
    assign half_msb = sign_ext_i & shifted[HALF_W-1];

    always_comb begin
        case (size_i)
            mem_bus_pkg::SZ_BYTE: loaded = {{(DATA_W-LANE_W){byte_msb}}, shifted[LANE_W-1:0]};
            mem_bus_pkg::SZ_HALF: loaded = {{(DATA_W-HALF_W){half_msb}}, shifted[HALF_W-1:0]};
            // word loads are aligned, take it whole
            default:              loaded = ram_rdata_i;
        endcase
    end

    // faulting load returns zero
    // non-load keeps the execute result
    always_comb begin
        if (!is_load_i) begin
            wdata_o = ex_wdata_i;
        end else if (fault_i) begin
            wdata_o = '0;
        end else begin
            wdata_o = loaded;
        end
    end

endmodule

// File: exc_capture.sv
`timescale 1ns/10ps

module exc_capture #(
    parameter int DATA_W = 32
) (
    input  logic                    fault_i,
    input  mips_isa_pkg::exc_code_e fault_code_i,
    input  mips_isa_pkg::exc_code_e exc_code_i,
    input  logic [DATA_W-1:0]       exc_epc_i,
    input  logic [DATA_W-1:0]       exc_badvaddr_i,
    input  logic [DATA_W-1:0]       pc_i,
    input  logic                    in_delay_i,
    input  logic [DATA_W-1:0]       addr_i,
    output mips_isa_pkg::exc_code_e code_o,
    output logic [DATA_W-1:0]       epc_o,
    output logic [DATA_W-1:0]       badvaddr_o
);

    logic [DATA_W-1:0] local_epc;

    // restart point is the branch when in a delay slot
    assign local_epc = in_delay_i ? (pc_i - DATA_W'(mips_isa_pkg::PC_STEP)) : pc_i;

    // local alignment fault takes priority over upstream
    always_comb begin
        if (fault_i) begin
            code_o     = fault_code_i;
            epc_o      = local_epc;
            // raw virtual address, before masking
            badvaddr_o = addr_i;
        end else begin
            code_o     = exc_code_i;
            epc_o      = exc_epc_i;
            badvaddr_o = exc_badvaddr_i;
        end
    end

endmodule

// File: mem_wb_reg.sv
`timescale 1ns/10ps

module mem_wb_reg #(
    parameter int DATA_W  = 32,
    parameter int RADDR_W = 5
) (
    input  logic                    cpu_clk_i,
    input  logic                    arst_n_i,
    input  logic [RADDR_W-1:0]      wd_i,
    input  logic                    wreg_i,
    input  logic [DATA_W-1:0]       wdata_i,
    input  mips_isa_pkg::exc_code_e code_i,
    input  logic [DATA_W-1:0]       epc_i,
    input  logic [DATA_W-1:0]       badvaddr_i,
    output logic [RADDR_W-1:0]      wb_wd_o,
    output logic                    wb_wreg_o,
    output logic [DATA_W-1:0]       wb_wdata_o,
    output mips_isa_pkg::exc_code_e exc_code_o,
    output logic [DATA_W-1:0]       exc_epc_o,
    output logic [DATA_W-1:0]       exc_badvaddr_o
);

    logic wreg_ok;

    // any pending exception blocks the register file write
    assign wreg_ok = wreg_i & (code_i == mips_isa_pkg::EC_NONE);

    ////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge cpu_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_wd_o        <= '0;
            wb_wreg_o      <= 1'b0;
            wb_wdata_o     <= '0;
            // idle, nothing pending
            exc_code_o     <= mips_isa_pkg::EC_NONE;
            exc_epc_o      <= '0;
            exc_badvaddr_o <= '0;
        end else begin
            wb_wd_o        <= wd_i;
            wb_wreg_o      <= wreg_ok;
            wb_wdata_o     <= wdata_i;
            exc_code_o     <= code_i;
            exc_epc_o      <= epc_i;
            exc_badvaddr_o <= badvaddr_i;
        end
    end

endmodule

// File: mem_stage.sv
`timescale 1ns/10ps

module mem_stage #(
    parameter int DATA_W  = mips_isa_pkg::WORD_W,
    parameter int RADDR_W = mips_isa_pkg::REG_ADDR_W
) (
    input  logic                    cpu_clk_i,
    input  logic                    arst_n_i,
    // operation from execute
    input  mips_isa_pkg::aluop_e    aluop_i,
    input  logic [DATA_W-1:0]       addr_i,
    input  logic [DATA_W-1:0]       reg2_i,
    input  logic [DATA_W-1:0]       ex_wdata_i,
    input  logic [DATA_W-1:0]       pc_i,
    input  logic [RADDR_W-1:0]      wd_i,
    input  logic                    wreg_i,
    input  logic                    in_delay_i,
    input  mips_isa_pkg::exc_code_e exc_code_i,
    input  logic [DATA_W-1:0]       exc_epc_i,
    input  logic [DATA_W-1:0]       exc_badvaddr_i,
    // data ram port
    input  logic [DATA_W-1:0]       ram_rdata_i,
    output logic                    ram_ce_o,
    output logic                    ram_we_o,
    output mem_bus_pkg::lane_sel_t  ram_sel_o,
    output logic [DATA_W-1:0]       ram_addr_o,
    output logic [DATA_W-1:0]       ram_wdata_o,
    // registered results to writeback
    output logic [RADDR_W-1:0]      wb_wd_o,
    output logic                    wb_wreg_o,
    output logic [DATA_W-1:0]       wb_wdata_o,
    output mips_isa_pkg::exc_code_e exc_code_o,
    output logic [DATA_W-1:0]       exc_epc_o,
    output logic [DATA_W-1:0]       exc_badvaddr_o
);

    mem_bus_pkg::access_size_e                size;
    logic                                     sign_ext;
    logic                                     is_load;
    logic [mem_bus_pkg::LANE_IDX_W-1:0]       lane;
    logic                                     fault;
    mips_isa_pkg::exc_code_e                  fault_code;
    logic [DATA_W-1:0]                        wdata;
    mips_isa_pkg::exc_code_e                  code;
    logic [DATA_W-1:0]                        epc;
    logic [DATA_W-1:0]                        badvaddr;

    ////////////////////////////////////////////////////////////
    // request side, same cycle
    ////////////////////////////////////////////////////////////

    mem_access_ctrl #(.DATA_W(DATA_W)) ctrl_inst (
        .arst_n_i     (arst_n_i),
        .aluop_i      (aluop_i),
        .addr_i       (addr_i),
        .ram_ce_o     (ram_ce_o),
        .ram_we_o     (ram_we_o),
        .ram_sel_o    (ram_sel_o),
        .ram_addr_o   (ram_addr_o),
        .size_o       (size),
        .sign_ext_o   (sign_ext),
        .is_load_o    (is_load),
        .lane_o       (lane),
        .fault_o      (fault),
        .fault_code_o (fault_code)
    );

    // write enable doubles as the store qualifier
    store_align #(.DATA_W(DATA_W)) store_inst (
        .reg2_i      (reg2_i),
        .size_i      (size),
        .lane_i      (lane),
        .is_store_i  (ram_we_o),
        .ram_wdata_o (ram_wdata_o)
    );

    // result side, captured at the clock edge
    load_extract #(.DATA_W(DATA_W)) load_inst (
        .ram_rdata_i (ram_rdata_i),
        .ex_wdata_i  (ex_wdata_i),
        .size_i      (size),
        .sign_ext_i  (sign_ext),
        .is_load_i   (is_load),
        .lane_i      (lane),
        .fault_i     (fault),
        .wdata_o     (wdata)
    );

    exc_capture #(.DATA_W(DATA_W)) exc_inst (
        .fault_i        (fault),
        .fault_code_i   (fault_code),
        .exc_code_i     (exc_code_i),
        .exc_epc_i      (exc_epc_i),
        .exc_badvaddr_i (exc_badvaddr_i),
        .pc_i           (pc_i),
        .in_delay_i     (in_delay_i),
        .addr_i         (addr_i),
        .code_o         (code),
        .epc_o          (epc),
        .badvaddr_o     (badvaddr)
    );

    mem_wb_reg #(.DATA_W(DATA_W), .RADDR_W(RADDR_W)) wb_reg_inst (
        .cpu_clk_i      (cpu_clk_i),
        .arst_n_i       (arst_n_i),
        .wd_i           (wd_i),
        .wreg_i         (wreg_i),
        .wdata_i        (wdata),
        .code_i         (code),
        .epc_i          (epc),
        .badvaddr_i     (badvaddr),
        .wb_wd_o        (wb_wd_o),
        .wb_wreg_o      (wb_wreg_o),
        .wb_wdata_o     (wb_wdata_o),
        .exc_code_o     (exc_code_o),
        .exc_epc_o      (exc_epc_o),
        .exc_badvaddr_o (exc_badvaddr_o)
    );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 16
) (
    output logic clk_o,
    output logic arst_n_o
);

    // free running clock, low at time zero
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release on a falling edge, clear of the capture edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

// File: tb_mem_stage.sv
`timescale 1ns/10ps

module tb_mem_stage;

    localparam int CLK_PERIOD_NS = 20;
    localparam int HALF_NS       = CLK_PERIOD_NS / 2;
    localparam int RST_CYCLES    = 16;
    localparam int DATA_W        = mips_isa_pkg::WORD_W;
    localparam int RADDR_W       = mips_isa_pkg::REG_ADDR_W;
    // slot 0 holds the reset check
    // file vectors start at slot 1
    localparam int MAX_VEC       = 64;
    localparam logic [31:0] SEED = 32'he24a9290;

    logic                    clk;
    logic                    arst_n;
    // dut inputs
    mips_isa_pkg::aluop_e    aluop;
    logic [DATA_W-1:0]       addr;
    logic [DATA_W-1:0]       reg2;
    logic [DATA_W-1:0]       ex_wdata;
    logic [DATA_W-1:0]       pc;
    logic [RADDR_W-1:0]      wd;
    logic                    wreg;
    logic                    in_delay;
    mips_isa_pkg::exc_code_e up_code;
    logic [DATA_W-1:0]       up_epc;
    logic [DATA_W-1:0]       up_badvaddr;
    logic [DATA_W-1:0]       ram_rdata;
    // dut outputs
    logic                    ram_ce;
    logic                    ram_we;
    mem_bus_pkg::lane_sel_t  ram_sel;
    logic [DATA_W-1:0]       ram_addr;
    logic [DATA_W-1:0]       ram_wdata;
    logic [RADDR_W-1:0]      wb_wd;
    logic                    wb_wreg;
    logic [DATA_W-1:0]       wb_wdata;
    mips_isa_pkg::exc_code_e exc_code;
    logic [DATA_W-1:0]       exc_epc;
    logic [DATA_W-1:0]       exc_badvaddr;

    // stimulus columns of the vector file
    string       names [MAX_VEC];
    logic [31:0] op_v [MAX_VEC], addr_v [MAX_VEC], reg2_v [MAX_VEC], exwd_v [MAX_VEC],
                 pc_v [MAX_VEC], wd_v [MAX_VEC], wreg_v [MAX_VEC], dly_v [MAX_VEC],
                 ecode_v [MAX_VEC], eepc_v [MAX_VEC], ebad_v [MAX_VEC],
                 rdata_v [MAX_VEC], rnd_v [MAX_VEC];
    // expected request and registered columns
    logic [31:0] ce_x [MAX_VEC], we_x [MAX_VEC], sel_x [MAX_VEC], raddr_x [MAX_VEC],
                 rwdata_x [MAX_VEC], wd_x [MAX_VEC], wreg_x [MAX_VEC], wdata_x [MAX_VEC],
                 code_x [MAX_VEC], epc_x [MAX_VEC], bad_x [MAX_VEC];

    int test_errs [MAX_VEC];
    // vectors whose registered result is still due
    int pending [$];
    int n_vec        = 0;
    int errors       = 0;
    int failed_tests = 0;
    bit loaded       = 1'b0;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RST_CYCLES(RST_CYCLES)) clk_gen_inst (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    mem_stage #(.DATA_W(DATA_W), .RADDR_W(RADDR_W)) mem_stage_inst (
        .cpu_clk_i      (clk),
        .arst_n_i       (arst_n),
        .aluop_i        (aluop),
        .addr_i         (addr),
        .reg2_i         (reg2),
        .ex_wdata_i     (ex_wdata),
        .pc_i           (pc),
        .wd_i           (wd),
        .wreg_i         (wreg),
        .in_delay_i     (in_delay),
        .exc_code_i     (up_code),
        .exc_epc_i      (up_epc),
        .exc_badvaddr_i (up_badvaddr),
        .ram_rdata_i    (ram_rdata),
        .ram_ce_o       (ram_ce),
        .ram_we_o       (ram_we),
        .ram_sel_o      (ram_sel),
        .ram_addr_o     (ram_addr),
        .ram_wdata_o    (ram_wdata),
        .wb_wd_o        (wb_wd),
        .wb_wreg_o      (wb_wreg),
        .wb_wdata_o     (wb_wdata),
        .exc_code_o     (exc_code),
        .exc_epc_o      (exc_epc),
        .exc_badvaddr_o (exc_badvaddr)
    );

    ////////////////////////////////////////////////////////////
    // reference rules
    ////////////////////////////////////////////////////////////

    // any of the five load opcodes
    function automatic bit is_load_op(logic [7:0] op);
        return op == mips_isa_pkg::OP_LB || op == mips_isa_pkg::OP_LBU ||
               op == mips_isa_pkg::OP_LH || op == mips_isa_pkg::OP_LHU ||
               op == mips_isa_pkg::OP_LW;
    endfunction

    // halfword wants an even address and word a multiple of four
    function automatic bit misaligned(logic [7:0] op, logic [31:0] va);
        if (op == mips_isa_pkg::OP_LH || op == mips_isa_pkg::OP_LHU ||
            op == mips_isa_pkg::OP_SH) begin
            return va[0];
        end
        if (op == mips_isa_pkg::OP_LW || op == mips_isa_pkg::OP_SW) begin
            return va[1:0] != 2'b00;
        end
        return 1'b0;
    endfunction

    task automatic check_value(input int idx, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s expected %h actual %h", names[idx], field, expected, actual);
            test_errs[idx]++;
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // vector file
    ////////////////////////////////////////////////////////////

    task automatic load_vectors();
        int    fd;
        int    cnt;
        int    i;
        string line;
        fd = $fopen("mem_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file mem_stim.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && n_vec < MAX_VEC - 1) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            // skip blank and comment lines
            if (line.len() < 2 || line.getc(0) == "#") continue;
            i = n_vec + 1;
            cnt = $sscanf(line,
                "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                names[i], op_v[i], addr_v[i], reg2_v[i], exwd_v[i], pc_v[i], wd_v[i],
                wreg_v[i], dly_v[i], ecode_v[i], eepc_v[i], ebad_v[i], rdata_v[i], rnd_v[i],
                ce_x[i], we_x[i], sel_x[i], raddr_x[i], rwdata_x[i], wd_x[i], wreg_x[i],
                wdata_x[i], code_x[i], epc_x[i], bad_x[i]);
            if (cnt != 25) begin
                $display("vector line could not be parsed: %s", line);
                errors++;
                continue;
            end
            n_vec = i;
            // random pc and alu result drive the expected fields
            if (rnd_v[i] != 0) begin
                pc_v[i]   = $urandom() & 32'hFFFF_FFFC;
                exwd_v[i] = $urandom();
                if (!is_load_op(op_v[i][7:0])) wdata_x[i] = exwd_v[i];
                if (misaligned(op_v[i][7:0], addr_v[i])) begin
                    epc_x[i] = dly_v[i][0] ? pc_v[i] - mips_isa_pkg::PC_STEP : pc_v[i];
                end
            end
        end
        $fclose(fd);
        if (n_vec == 0) begin
            $display("the vector file holds no usable vectors");
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // drive and check
    ////////////////////////////////////////////////////////////

    task automatic drive_idle();
        aluop       = mips_isa_pkg::OP_NOP;
        addr        = '0;
        reg2        = '0;
        ex_wdata    = '0;
        pc          = '0;
        wd          = '0;
        wreg        = 1'b0;
        in_delay    = 1'b0;
        up_code     = mips_isa_pkg::EC_NONE;
        up_epc      = '0;
        up_badvaddr = '0;
        ram_rdata   = '0;
    endtask

    task automatic drive_vector(input int i);
        aluop       = mips_isa_pkg::aluop_e'(op_v[i][7:0]);
        addr        = addr_v[i];
        reg2        = reg2_v[i];
        ex_wdata    = exwd_v[i];
        pc          = pc_v[i];
        wd          = wd_v[i][RADDR_W-1:0];
        wreg        = wreg_v[i][0];
        in_delay    = dly_v[i][0];
        up_code     = mips_isa_pkg::exc_code_e'(ecode_v[i][4:0]);
        up_epc      = eepc_v[i];
        up_badvaddr = ebad_v[i];
        // read word as the ram would return it this cycle
        ram_rdata   = rdata_v[i];
    endtask

    task automatic check_request(input int i);
        check_value(i, "ram_ce", ce_x[i], 32'(ram_ce));
        check_value(i, "ram_we", we_x[i], 32'(ram_we));
        check_value(i, "ram_sel", sel_x[i], 32'(ram_sel));
        check_value(i, "ram_addr", raddr_x[i], ram_addr);
        check_value(i, "ram_wdata", rwdata_x[i], ram_wdata);
    endtask

    task automatic check_registered(input int i);
        check_value(i, "wb_wd", wd_x[i], 32'(wb_wd));
        check_value(i, "wb_wreg", wreg_x[i], 32'(wb_wreg));
        check_value(i, "wb_wdata", wdata_x[i], wb_wdata);
        check_value(i, "exc_code", code_x[i], 32'(exc_code));
        check_value(i, "exc_epc", epc_x[i], exc_epc);
        check_value(i, "exc_badvaddr", bad_x[i], exc_badvaddr);
    endtask

    // stage register idle values
    task automatic check_idle();
        check_value(0, "wb_wd", 32'd0, 32'(wb_wd));
        check_value(0, "wb_wreg", 32'd0, 32'(wb_wreg));
        check_value(0, "wb_wdata", 32'd0, wb_wdata);
        check_value(0, "exc_code", 32'(mips_isa_pkg::EC_NONE), 32'(exc_code));
        check_value(0, "exc_epc", 32'd0, exc_epc);
        check_value(0, "exc_badvaddr", 32'd0, exc_badvaddr);
    endtask

    task automatic report_test(input int i);
        if (test_errs[i] == 0) begin
            $display("test %-14s ok", names[i]);
        end else begin
            $display("test %-14s FAILED with %0d errors", names[i], test_errs[i]);
            failed_tests++;
        end
    endtask

    // registered result of the previous vector
    // the inputs already hold the next one
    task automatic check_pending();
        int idx;
        if (pending.size() > 0) begin
            idx = pending.pop_front();
            check_registered(idx);
            report_test(idx);
        end
    endtask

    initial begin
        drive_idle();
        names[0] = "reset_idle";
        void'($urandom(SEED));
        load_vectors();
        loaded = 1'b1;
        // store held during reset keeps the strobes low
        @(negedge clk);
        aluop = mips_isa_pkg::OP_SW;
        addr  = 32'h0000_0200;
        reg2  = 32'hA5A5_A5A5;
        wreg  = 1'b1;
        #1;
        check_value(0, "ram_ce", 32'd0, 32'(ram_ce));
        check_value(0, "ram_we", 32'd0, 32'(ram_we));
        check_idle();
        // release comes on a falling edge
        @(posedge arst_n);
        drive_idle();
        #1;
        check_idle();
        report_test(0);
        // one vector per cycle back to back
        for (int i = 1; i <= n_vec; i++) begin
            @(negedge clk);
            drive_vector(i);
            // both sides sampled just ahead of the rising edge
            #(HALF_NS - 1);
            check_pending();
            check_request(i);
            pending.push_back(i);
        end
        @(negedge clk);
        drive_idle();
        #(HALF_NS - 1);
        check_pending();
        $display("%0d tests, %0d failed, %0d errors", n_vec + 1, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // run limit scales with the vector count
    initial begin
        wait (loaded);
        #((n_vec + 20) * CLK_PERIOD_NS);
        $display("timeout, the vectors did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: mem_stim.txt
# name op addr reg2 ex_wdata pc wd wreg dly exc_code exc_epc exc_badvaddr ram_rdata rnd
# then expected: ce we sel ram_addr ram_wdata wb_wd wb_wreg wb_wdata exc_code exc_epc exc_badvaddr
lb_lane0 20 80000100 0 0 400000 3 1 0 1f 0 0 6a12f384 0 1 0 1 100 0 3 1 ffffff84 1f 0 0
lb_lane1 20 a0000101 0 0 400004 3 1 0 1f 0 0 6a12f384 0 1 0 2 101 0 3 1 fffffff3 1f 0 0
lb_lane2 20 102 0 0 400008 3 1 0 1f 0 0 6a12f384 0 1 0 4 102 0 3 1 12 1f 0 0
lb_lane3 20 107 0 0 40000c 3 1 0 1f 0 0 6a12f384 0 1 0 8 107 0 3 1 6a 1f 0 0
lbu_lane0 24 104 0 0 400010 a 1 0 1f 0 0 6a12f384 0 1 0 1 104 0 a 1 84 1f 0 0
lh_lane0 21 108 0 0 400014 b 1 0 1f 0 0 6a12f384 0 1 0 3 108 0 b 1 fffff384 1f 0 0
lh_lane2 21 e000010a 0 0 400018 b 1 0 1f 0 0 6a12f384 0 1 0 c 10a 0 b 1 6a12 1f 0 0
lhu_lane0 25 10c 0 0 40001c c 1 0 1f 0 0 6a12f384 0 1 0 3 10c 0 c 1 f384 1f 0 0
lw_word 23 40000110 0 0 400020 d 1 0 1f 0 0 6a12f384 0 1 0 f 110 0 d 1 6a12f384 1f 0 0
sb_lane0 28 200 11223344 0 400024 0 0 0 1f 0 0 0 0 1 1 1 200 44 0 0 0 1f 0 0
sb_lane1 28 201 11223344 0 400028 0 0 0 1f 0 0 0 0 1 1 2 201 4400 0 0 0 1f 0 0
sb_lane2 28 80000202 11223344 0 40002c 0 0 0 1f 0 0 0 0 1 1 4 202 440000 0 0 0 1f 0 0
sb_lane3 28 203 11223344 0 400030 0 0 0 1f 0 0 0 0 1 1 8 203 44000000 0 0 0 1f 0 0
sh_lane2 29 206 11223344 0 400034 0 0 0 1f 0 0 0 0 1 1 c 206 33440000 0 0 0 1f 0 0
sw_word 2b 208 11223344 0 400038 0 0 0 1f 0 0 0 0 1 1 f 208 11223344 0 0 0 1f 0 0
lh_odd 21 80000301 0 0 400100 4 1 0 1f 0 0 6a12f384 0 1 0 0 301 0 4 0 0 4 400100 80000301
lhu_odd_dly 25 303 0 0 0 5 1 1 1f 0 0 6a12f384 1 1 0 0 303 0 5 0 0 4 0 303
lw_mis_dly 23 302 0 0 400104 6 1 1 1f 0 0 6a12f384 0 1 0 0 302 0 6 0 0 4 400100 302
sh_odd 29 305 0 0 400200 0 0 0 1f 0 0 0 0 1 1 0 305 0 0 0 0 5 400200 305
sw_mis_rnd 2b 8000030a 0 0 0 0 0 0 1f 0 0 0 1 1 1 0 30a 0 0 0 0 5 0 8000030a
alu_pass 0c 80001234 5 deadbeef 400300 7 1 0 1f 0 0 0 0 0 0 0 0 0 7 1 deadbeef 1f 0 0
nop_rnd 00 0 0 0 0 9 1 0 1f 0 0 0 1 0 0 0 0 0 9 1 0 1f 0 0
upstream_exc 0c 0 0 12345678 400400 8 1 0 4 400400 400402 0 0 0 0 0 0 0 8 0 12345678 4 400400 400402
upstream_lw 23 110 0 0 400500 2 1 0 5 400480 1000 6a12f384 0 1 0 f 110 0 2 0 6a12f384 5 400480 1000

// File: vlog.f
mips_isa_pkg.sv
mem_bus_pkg.sv
mem_access_ctrl.sv
store_align.sv
load_extract.sv
exc_capture.sv
mem_wb_reg.sv
mem_stage.sv
tb_clk_gen.sv
tb_mem_stage.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, and decide pass or fail from the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_mem_stage -f vlog.f -o sim_mem_stage || exit 1
out=$(./obj_dir/sim_mem_stage)
echo "$out"
echo "$out" | grep -qx "Simulation completed successfully" && exit 0 || exit 1
